/* free_list.sv */
`timescale 1ns/1ps

module free_list
    import rv32i_types::*;
    import rename_cfg_pkg::*;
(
    input  logic                     clk,
    input  logic                     rst,
    input  logic                     alloc,
    input  logic                     push,
    input  logic [PHYS_REG_BITS-1:0] push_pd,
    input  logic                     commit,
    input  logic                     flush,
    output logic [PHYS_REG_BITS-1:0] head_pd,
    output logic                     empty
);

    logic [PHYS_REG_BITS-1:0] queue [FREE_REGS];

    // head allocates, tail takes returned registers,
    // commit_ptr trails head by the speculative allocations
    logic [FREE_PTR_BITS-1:0] head;
    logic [FREE_PTR_BITS-1:0] tail;
    logic [FREE_PTR_BITS-1:0] commit_ptr;
    logic [FREE_PTR_BITS-1:0] commit_ptr_next;
    logic [FREE_PTR_BITS-1:0] count;
    logic                     full;

    assign count = tail - head;
    assign empty = (count == '0);
    assign full  = (count == FREE_PTR_BITS'(FREE_REGS));

    assign head_pd = queue[head[FREE_PTR_BITS-2:0]];

    // a commit in the flush cycle belongs to the committed state
    assign commit_ptr_next = commit ? commit_ptr + 1'b1 : commit_ptr;

    always_ff @(posedge clk) begin
        if (rst) begin
            head       <= '0;
            tail       <= FREE_PTR_BITS'(FREE_REGS);
            commit_ptr <= '0;
        end else begin
            commit_ptr <= commit_ptr_next;
            if (flush) begin
                head <= commit_ptr_next;
            end else if (alloc) begin
                head <= head + 1'b1;
            end
            if (push) begin
                tail <= tail + 1'b1;
            end
        end
    end

    // queue starts with every register above the architectural ones
    always_ff @(posedge clk) begin
        if (rst) begin
            for (int i = 0; i < FREE_REGS; i++) begin
                queue[i] <= PHYS_REG_BITS'(ARCH_REGS + i);
            end
        end else if (push) begin
            queue[tail[FREE_PTR_BITS-2:0]] <= push_pd;
        end
    end

    // the controller must hold off the fire while empty
    no_alloc_empty: assert property (@(posedge clk) disable iff (rst)
        alloc |-> !empty);

    // returns never outnumber the registers handed out
    no_push_full: assert property (@(posedge clk) disable iff (rst)
        push |-> !full);

endmodule : free_list

/* rat.sv */
`timescale 1ns/1ps

module rat
    import rv32i_types::*;
    import rename_cfg_pkg::*;
(
    input  logic                     clk,
    input  logic                     rst,
    input  rv32i_opcode_t            opcode,
    input  logic [ARCH_REG_BITS-1:0] rd,
    input  logic [ARCH_REG_BITS-1:0] rs1,
    input  logic [ARCH_REG_BITS-1:0] rs2,
    input  logic                     rename_fire,
    input  logic [PHYS_REG_BITS-1:0] new_pd,
    input  logic                     cdb_alu_valid,
    input  logic [ARCH_REG_BITS-1:0] cdb_alu_rd,
    input  logic [PHYS_REG_BITS-1:0] cdb_alu_pd,
    input  logic                     cdb_mem_valid,
    input  logic [ARCH_REG_BITS-1:0] cdb_mem_rd,
    input  logic [PHYS_REG_BITS-1:0] cdb_mem_pd,
    input  logic                     flush,
    input  logic [PHYS_REG_BITS-1:0] committed_map [ARCH_REGS],
    output logic                     needs_dest,
    output logic [PHYS_REG_BITS-1:0] src1_phys,
    output logic                     src1_ready,
    output logic [PHYS_REG_BITS-1:0] src2_phys,
    output logic                     src2_ready
);

    logic [PHYS_REG_BITS-1:0] map [ARCH_REGS];
    logic                     ready [ARCH_REGS];
    logic [PHYS_REG_BITS-1:0] map_next [ARCH_REGS];
    logic                     ready_next [ARCH_REGS];
    logic                     uses_rs1;
    logic                     uses_rs2;

    // stores and branches write nothing, x0 is never renamed
    assign needs_dest = !(opcode inside {op_b_store, op_b_br}) && (rd != '0);

    assign uses_rs1 = (opcode != op_b_jal);
    assign uses_rs2 = opcode inside {op_b_br, op_b_store, op_b_reg};

    // lookups see the table before this cycle's updates
    always_comb begin
        if (uses_rs1) begin
            src1_phys  = map[rs1];
            src1_ready = ready[rs1];
        end else begin
            src1_phys  = '0;
            src1_ready = 1'b1;
        end

        if (uses_rs2) begin
            src2_phys  = map[rs2];
            src2_ready = ready[rs2];
        end else begin
            src2_phys  = '0;
            src2_ready = 1'b1;
        end
    end

    always_comb begin
        map_next   = map;
        ready_next = ready;

        // wakeup only counts if rd still points at the written pd
        if (cdb_alu_valid && (map[cdb_alu_rd] == cdb_alu_pd)) begin
            ready_next[cdb_alu_rd] = 1'b1;
        end
        if (cdb_mem_valid && (map[cdb_mem_rd] == cdb_mem_pd)) begin
            ready_next[cdb_mem_rd] = 1'b1;
        end

        // a new mapping overrides any wakeup of the old one
        if (rename_fire && needs_dest) begin
            map_next[rd]   = new_pd;
            ready_next[rd] = 1'b0;
        end

        // back to the retired state, all values are in the register file
        if (flush) begin
            for (int i = 0; i < ARCH_REGS; i++) begin
                map_next[i]   = committed_map[i];
                ready_next[i] = 1'b1;
            end
        end
    end

    always_ff @(posedge clk) begin
        if (rst) begin
            for (int i = 0; i < ARCH_REGS; i++) begin
                map[i]   <= PHYS_REG_BITS'(i);
                ready[i] <= 1'b1;
            end
        end else begin
            map   <= map_next;
            ready <= ready_next;
        end
    end

    // x0 stays pinned across renames, wakeups and flushes
    x0_pinned: assert property (@(posedge clk) disable iff (rst)
        (map[0] == '0) && ready[0]);

endmodule : rat

/* rename_cfg_pkg.sv */
package rename_cfg_pkg;

    // physical register file
    localparam int PHYS_REGS     = 64;
    localparam int PHYS_REG_BITS = $clog2(PHYS_REGS);

    // registers not backing an architectural register at reset
    localparam int FREE_REGS = PHYS_REGS - rv32i_types::ARCH_REGS;

    // extra msb tells a full queue from an empty one
    localparam int FREE_PTR_BITS = $clog2(FREE_REGS) + 1;

    // dispatch controller states
    typedef enum logic [1:0] {
        // waiting for a request or a flush
        idle,
        // renamed result held, waiting for req to drop
        ack_high,
        // one recovery cycle after a flush pulse
        flushing
    } rename_state_t;

endpackage : rename_cfg_pkg

/* rename_top.sv */
`timescale 1ns/1ps

module rename_top
    import rv32i_types::*;
    import rename_cfg_pkg::*;
(
    input  logic                     clk,
    input  logic                     rst,
    // dispatch
    input  logic                     dispatch_req,
    input  rv32i_opcode_t            opcode,
    input  logic [ARCH_REG_BITS-1:0] rd,
    input  logic [ARCH_REG_BITS-1:0] rs1,
    input  logic [ARCH_REG_BITS-1:0] rs2,
    output logic                     dispatch_ack,
    output logic [PHYS_REG_BITS-1:0] ps1,
    output logic                     ps1_ready,
    output logic [PHYS_REG_BITS-1:0] ps2,
    output logic                     ps2_ready,
    output logic [PHYS_REG_BITS-1:0] pd,
    output logic                     pd_valid,
    // commit
    input  logic                     commit_valid,
    input  logic [ARCH_REG_BITS-1:0] commit_rd,
    input  logic [PHYS_REG_BITS-1:0] commit_pd,
    // writeback
    input  logic                     cdb_alu_valid,
    input  logic [ARCH_REG_BITS-1:0] cdb_alu_rd,
    input  logic [PHYS_REG_BITS-1:0] cdb_alu_pd,
    input  logic                     cdb_mem_valid,
    input  logic [ARCH_REG_BITS-1:0] cdb_mem_rd,
    input  logic [PHYS_REG_BITS-1:0] cdb_mem_pd,
    input  logic                     flush
);

    logic                     needs_dest;
    logic [PHYS_REG_BITS-1:0] src1_phys;
    logic                     src1_ready;
    logic [PHYS_REG_BITS-1:0] src2_phys;
    logic                     src2_ready;
    logic                     empty;
    logic [PHYS_REG_BITS-1:0] head_pd;
    logic                     rename_fire;
    logic                     alloc;
    logic [PHYS_REG_BITS-1:0] old_pd;
    logic                     free_push;
    logic [PHYS_REG_BITS-1:0] committed_map [ARCH_REGS];

    rat rat_inst (
        .clk, .rst, .opcode, .rd, .rs1, .rs2, .rename_fire,
        .new_pd        (head_pd),
        .cdb_alu_valid, .cdb_alu_rd, .cdb_alu_pd,
        .cdb_mem_valid, .cdb_mem_rd, .cdb_mem_pd,
        .flush, .committed_map,
        .needs_dest, .src1_phys, .src1_ready, .src2_phys, .src2_ready
    );

    free_list free_list_inst (
        .clk, .rst, .alloc,
        .push    (free_push),
        .push_pd (old_pd),
        .commit  (commit_valid),
        .flush, .head_pd, .empty
    );

    rrat rrat_inst (
        .clk, .rst, .commit_valid, .commit_rd, .commit_pd,
        .old_pd, .free_push, .committed_map
    );

    rename_unit rename_unit_inst (
        .clk, .rst, .dispatch_req, .needs_dest, .empty, .flush,
        .src1_phys, .src1_ready, .src2_phys, .src2_ready, .head_pd,
        .dispatch_ack, .rename_fire, .alloc,
        .ps1, .ps1_ready, .ps2, .ps2_ready, .pd, .pd_valid
    );

endmodule : rename_top

/* rename_unit.sv */
`timescale 1ns/1ps

module rename_unit
    import rename_cfg_pkg::*;
(
    input  logic                     clk,
    input  logic                     rst,
    input  logic                     dispatch_req,
    input  logic                     needs_dest,
    input  logic                     empty,
    input  logic                     flush,
    input  logic [PHYS_REG_BITS-1:0] src1_phys,
    input  logic                     src1_ready,
    input  logic [PHYS_REG_BITS-1:0] src2_phys,
    input  logic                     src2_ready,
    input  logic [PHYS_REG_BITS-1:0] head_pd,
    output logic                     dispatch_ack,
    output logic                     rename_fire,
    output logic                     alloc,
    output logic [PHYS_REG_BITS-1:0] ps1,
    output logic                     ps1_ready,
    output logic [PHYS_REG_BITS-1:0] ps2,
    output logic                     ps2_ready,
    output logic [PHYS_REG_BITS-1:0] pd,
    output logic                     pd_valid
);

    rename_state_t state;
    rename_state_t state_next;

    // instructions without rd go even when no register is free
    assign rename_fire = (state == idle) && dispatch_req && !flush
                         && (!needs_dest || !empty);
    assign alloc = rename_fire && needs_dest;

    assign dispatch_ack = (state == ack_high);

    always_comb begin
        state_next = state;
        unique case (state)
            idle: begin
                if (flush) begin
                    state_next = flushing;
                end else if (rename_fire) begin
                    state_next = ack_high;
                end
            end
            ack_high: begin
                // four-phase handshake waits for the requester to let go
                if (!dispatch_req) begin
                    state_next = idle;
                end
            end
            flushing: begin
                state_next = idle;
            end
            default: begin
                state_next = idle;
            end
        endcase
    end

    always_ff @(posedge clk) begin
        if (rst) begin
            state <= idle;
        end else begin
            state <= state_next;
        end
    end

    // capture the lookup at the fire edge and hold it while acked
    always_ff @(posedge clk) begin
        if (rename_fire) begin
            ps1       <= src1_phys;
            ps1_ready <= src1_ready;
            ps2       <= src2_phys;
            ps2_ready <= src2_ready;
            pd        <= needs_dest ? head_pd : '0;
            pd_valid  <= needs_dest;
        end
    end

    // ack only rises while the request is still up
    ack_needs_req: assert property (@(posedge clk) disable iff (rst)
        $rose(dispatch_ack) |-> dispatch_req);

    // flush only comes between transactions
    flush_when_idle: assert property (@(posedge clk) disable iff (rst)
        flush |-> (state == idle));

endmodule : rename_unit

/* rrat.sv */
`timescale 1ns/1ps

module rrat
    import rv32i_types::*;
    import rename_cfg_pkg::*;
(
    input  logic                     clk,
    input  logic                     rst,
    input  logic                     commit_valid,
    input  logic [ARCH_REG_BITS-1:0] commit_rd,
    input  logic [PHYS_REG_BITS-1:0] commit_pd,
    output logic [PHYS_REG_BITS-1:0] old_pd,
    output logic                     free_push,
    output logic [PHYS_REG_BITS-1:0] committed_map [ARCH_REGS]
);

    logic [PHYS_REG_BITS-1:0] map [ARCH_REGS];

    // the mapping being retired goes back to the free list
    assign old_pd    = map[commit_rd];
    assign free_push = commit_valid;

    // includes this cycle's commit so a same-cycle flush sees it
    always_comb begin
        committed_map = map;
        if (commit_valid) begin
            committed_map[commit_rd] = commit_pd;
        end
    end

    always_ff @(posedge clk) begin
        if (rst) begin
            for (int i = 0; i < ARCH_REGS; i++) begin
                map[i] <= PHYS_REG_BITS'(i);
            end
        end else begin
            map <= committed_map;
        end
    end

endmodule : rrat

/* run.sh */
#!/usr/bin/env bash
set -e
set -o pipefail
cd "$(dirname "$0")"

verilator --binary --assert -Wno-fatal -f tb.f --top-module tb_rename -o tb_rename
./obj_dir/tb_rename | tee sim.log

if grep -q "Testbench failed" sim.log; then
    echo "simulation reported a failure"
    exit 1
fi
echo "simulation finished without failure"

/* rv32i_types.sv */
package rv32i_types;

    // architectural register file
    localparam int ARCH_REGS     = 32;
    localparam int ARCH_REG_BITS = $clog2(ARCH_REGS);

    // RV32I major opcodes, bits [6:0] of the instruction word
    typedef enum logic [6:0] {
        // load upper immediate
        op_b_lui   = 7'b0110111,
        // add upper immediate to pc
        op_b_auipc = 7'b0010111,
        // jump and link
        op_b_jal   = 7'b1101111,
        // jump and link register
        op_b_jalr  = 7'b1100111,
        // conditional branch
        op_b_br    = 7'b1100011,
        op_b_load  = 7'b0000011,
        op_b_store = 7'b0100011,
        // register-immediate alu ops, nop included
        op_b_imm   = 7'b0010011,
        // register-register alu ops
        op_b_reg   = 7'b0110011
    } rv32i_opcode_t;

endpackage : rv32i_types

/* tb.f */
rv32i_types.sv
rename_cfg_pkg.sv
rat.sv
free_list.sv
rrat.sv
rename_unit.sv
rename_top.sv
tb_rename.sv

/* tb_rename.sv */
`timescale 1ns/1ps

module tb_rename
    import rv32i_types::*;
    import rename_cfg_pkg::*;
();

    localparam int RESET_CYCLES = 10;
    localparam int N_RANDOM     = 400;
    localparam int N_DIRECTED   = 120;
    // a dispatch plus a commit ahead of it stays well under 8 cycles
    localparam int MAX_CYCLES   = (N_RANDOM + N_DIRECTED) * 8 + RESET_CYCLES + 500;

    typedef struct packed {
        logic [PHYS_REG_BITS-1:0] ps1;
        logic                     ps1_ready;
        logic [PHYS_REG_BITS-1:0] ps2;
        logic                     ps2_ready;
        logic [PHYS_REG_BITS-1:0] pd;
        logic                     pd_valid;
    } rename_result_t;

    logic                     clk;
    logic                     rst;
    logic                     dispatch_req;
    rv32i_opcode_t            opcode;
    logic [ARCH_REG_BITS-1:0] rd, rs1, rs2;
    logic                     dispatch_ack;
    logic [PHYS_REG_BITS-1:0] ps1, ps2, pd;
    logic                     ps1_ready, ps2_ready, pd_valid;
    logic                     commit_valid;
    logic [ARCH_REG_BITS-1:0] commit_rd;
    logic [PHYS_REG_BITS-1:0] commit_pd;
    logic                     cdb_alu_valid, cdb_mem_valid;
    logic [ARCH_REG_BITS-1:0] cdb_alu_rd, cdb_mem_rd;
    logic [PHYS_REG_BITS-1:0] cdb_alu_pd, cdb_mem_pd;
    logic                     flush;

    // reference model state
    logic [PHYS_REG_BITS-1:0] m_map [ARCH_REGS];
    logic                     m_ready [ARCH_REGS];
    logic [PHYS_REG_BITS-1:0] m_cmap [ARCH_REGS];
    logic [PHYS_REG_BITS-1:0] m_queue [FREE_REGS];
    int                       m_head, m_tail, m_cptr;
    int                       inflight_rd[$];
    int                       inflight_pd[$];

    rename_result_t expected_q[$];
    rv32i_opcode_t  op_list [9] = '{op_b_lui, op_b_auipc, op_b_jal, op_b_jalr, op_b_br,
                                    op_b_load, op_b_store, op_b_imm, op_b_reg};
    logic [31:0]    seed = 32'h8ebe_59c8;
    string          test_name = "reset";
    int             value_errors, other_errors, acks_checked, cycles;
    logic           ack_seen;

    rename_top rename_top_inst (.*);

    initial begin
        clk = 1'b0;
        forever #2 clk = ~clk;
    end

    function automatic int rand_below(int n);
        seed = seed * 32'd1664525 + 32'd1013904223;
        return int'(seed[31:8]) % n;
    endfunction

    function automatic logic writes_rd(rv32i_opcode_t op, logic [ARCH_REG_BITS-1:0] dst);
        return !(op == op_b_store || op == op_b_br) && (dst != '0);
    endfunction

    // expected renamed operands, and the allocation applied to the model
    function automatic rename_result_t ref_rename(rv32i_opcode_t op,
            logic [ARCH_REG_BITS-1:0] dst, logic [ARCH_REG_BITS-1:0] src_a,
            logic [ARCH_REG_BITS-1:0] src_b);
        rename_result_t res;
        res = '0;
        res.ps1_ready = 1'b1;
        res.ps2_ready = 1'b1;
        if (op != op_b_jal) begin
            res.ps1       = m_map[src_a];
            res.ps1_ready = m_ready[src_a];
        end
        if (op == op_b_br || op == op_b_store || op == op_b_reg) begin
            res.ps2       = m_map[src_b];
            res.ps2_ready = m_ready[src_b];
        end
        res.pd_valid = writes_rd(op, dst);
        if (res.pd_valid) begin
            res.pd = m_queue[m_head % FREE_REGS];
            m_head++;
            m_map[dst]   = res.pd;
            m_ready[dst] = 1'b0;
            inflight_rd.push_back(int'(dst));
            inflight_pd.push_back(int'(res.pd));
        end
        return res;
    endfunction

    task automatic check_phys(string field, logic [PHYS_REG_BITS-1:0] expected,
                              logic [PHYS_REG_BITS-1:0] actual);
        if (actual !== expected) begin
            $display("** Error: %s %s expected %0d actual %0d", test_name, field,
                     expected, actual);
            value_errors++;
        end
    endtask

    task automatic check_bit(string field, logic expected, logic actual);
        if (actual !== expected) begin
            $display("** Error: %s %s expected %0b actual %0b", test_name, field,
                     expected, actual);
            value_errors++;
        end
    endtask

    // compare once per ack at its first falling clock edge
    always @(negedge clk) begin
        rename_result_t want;
        if (!rst && dispatch_ack && !ack_seen) begin
            if (expected_q.size() == 0) begin
                $display("ack arrived with no request outstanding in %s", test_name);
                other_errors++;
            end else begin
                want = expected_q.pop_front();
                check_phys("ps1", want.ps1, ps1);
                check_bit("ps1_ready", want.ps1_ready, ps1_ready);
                check_phys("ps2", want.ps2, ps2);
                check_bit("ps2_ready", want.ps2_ready, ps2_ready);
                check_bit("pd_valid", want.pd_valid, pd_valid);
                if (want.pd_valid) begin
                    check_phys("pd", want.pd, pd);
                end
                acks_checked++;
            end
        end
        ack_seen = dispatch_ack;
    end

    always @(posedge clk) begin
        cycles++;
        if (cycles > MAX_CYCLES) begin
            $display("timeout after %0d cycles in %s", cycles, test_name);
            $display("Testbench failed");
            $finish;
        end
    end

    task automatic start_req(rv32i_opcode_t op, logic [ARCH_REG_BITS-1:0] dst,
            logic [ARCH_REG_BITS-1:0] src_a, logic [ARCH_REG_BITS-1:0] src_b);
        @(posedge clk);
        dispatch_req <= 1'b1;
        opcode       <= op;
        rd           <= dst;
        rs1          <= src_a;
        rs2          <= src_b;
    endtask

    // wait for ack, release req, then wait for ack to drop
    task automatic finish_req();
        @(posedge clk);
        while (!dispatch_ack) @(posedge clk);
        dispatch_req <= 1'b0;
        @(posedge clk);
        while (dispatch_ack) @(posedge clk);
    endtask

    task automatic dispatch(rv32i_opcode_t op, logic [ARCH_REG_BITS-1:0] dst,
            logic [ARCH_REG_BITS-1:0] src_a, logic [ARCH_REG_BITS-1:0] src_b);
        expected_q.push_back(ref_rename(op, dst, src_a, src_b));
        start_req(op, dst, src_a, src_b);
        finish_req();
    endtask

    // retire the oldest renamed destination
    task automatic commit_oldest();
        int c_rd, c_pd;
        c_rd = inflight_rd.pop_front();
        c_pd = inflight_pd.pop_front();
        @(posedge clk);
        commit_valid <= 1'b1;
        commit_rd    <= ARCH_REG_BITS'(c_rd);
        commit_pd    <= PHYS_REG_BITS'(c_pd);
        m_queue[m_tail % FREE_REGS] = m_cmap[c_rd];
        m_tail++;
        m_cmap[c_rd] = PHYS_REG_BITS'(c_pd);
        m_cptr++;
        @(posedge clk);
        commit_valid <= 1'b0;
    endtask

    task automatic write_cdb(bit on_mem, int w_rd, int w_pd);
        @(posedge clk);
        if (on_mem) begin
            cdb_mem_valid <= 1'b1;
            cdb_mem_rd    <= ARCH_REG_BITS'(w_rd);
            cdb_mem_pd    <= PHYS_REG_BITS'(w_pd);
        end else begin
            cdb_alu_valid <= 1'b1;
            cdb_alu_rd    <= ARCH_REG_BITS'(w_rd);
            cdb_alu_pd    <= PHYS_REG_BITS'(w_pd);
        end
        if (m_map[w_rd] == PHYS_REG_BITS'(w_pd)) begin
            m_ready[w_rd] = 1'b1;
        end
        @(posedge clk);
        cdb_alu_valid <= 1'b0;
        cdb_mem_valid <= 1'b0;
    endtask

    task automatic pulse_flush();
        @(posedge clk);
        flush <= 1'b1;
        @(posedge clk);
        flush <= 1'b0;
        m_map = m_cmap;
        for (int i = 0; i < ARCH_REGS; i++) begin
            m_ready[i] = 1'b1;
        end
        m_head = m_cptr;
        inflight_rd.delete();
        inflight_pd.delete();
    endtask

    initial begin
        rv32i_opcode_t            op;
        logic [ARCH_REG_BITS-1:0] r_d, r_a, r_b;
        int                       pick, idx;
        rst = 1'b1;
        dispatch_req = 1'b0;
        opcode = op_b_imm;
        rd = '0;
        rs1 = '0;
        rs2 = '0;
        commit_valid = 1'b0;
        commit_rd = '0;
        commit_pd = '0;
        cdb_alu_valid = 1'b0;
        cdb_alu_rd = '0;
        cdb_alu_pd = '0;
        cdb_mem_valid = 1'b0;
        cdb_mem_rd = '0;
        cdb_mem_pd = '0;
        flush = 1'b0;
        for (int i = 0; i < ARCH_REGS; i++) begin
            m_map[i]   = PHYS_REG_BITS'(i);
            m_cmap[i]  = PHYS_REG_BITS'(i);
            m_ready[i] = 1'b1;
        end
        for (int i = 0; i < FREE_REGS; i++) begin
            m_queue[i] = PHYS_REG_BITS'(ARCH_REGS + i);
        end
        m_head = 0;
        m_tail = FREE_REGS;
        m_cptr = 0;
        repeat (RESET_CYCLES) @(posedge clk);
        rst <= 1'b0;

        test_name = "reset_map";
        for (int i = 0; i < 16; i++) begin
            dispatch(op_b_reg, 0, ARCH_REG_BITS'(2 * i), ARCH_REG_BITS'(2 * i + 1));
        end
        dispatch(op_b_imm, 1, 0, 0);
        dispatch(op_b_imm, 2, 1, 0);
        dispatch(op_b_imm, 3, 2, 0);

        test_name = "renamed_source";
        dispatch(op_b_reg, 4, 1, 2);
        write_cdb(0, 1, 32);
        dispatch(op_b_reg, 0, 1, 3);
        // x2 renamed over, so the write for its older pd is stale
        dispatch(op_b_imm, 2, 0, 0);
        write_cdb(1, 2, 33);
        dispatch(op_b_reg, 0, 2, 1);

        test_name = "no_dest";
        dispatch(op_b_store, 5, 1, 2);
        dispatch(op_b_br, 6, 3, 4);
        dispatch(op_b_imm, 0, 1, 0);
        dispatch(op_b_jal, 7, 9, 9);
        dispatch(op_b_lui, 8, 3, 3);

        test_name = "backpressure";
        while (m_tail - m_head > 0) begin
            dispatch(op_b_imm, ARCH_REG_BITS'(1 + rand_below(31)),
                     ARCH_REG_BITS'(rand_below(32)), 0);
        end
        start_req(op_b_reg, 9, 1, 2);
        repeat (6) begin
            @(posedge clk);
            if (dispatch_ack) begin
                $display("ack arrived while the free list was empty");
                other_errors++;
            end
        end
        commit_oldest();
        expected_q.push_back(ref_rename(op_b_reg, 9, 1, 2));
        finish_req();

        test_name = "flush_restore";
        repeat (3) commit_oldest();
        dispatch(op_b_imm, 1, 2, 0);
        dispatch(op_b_reg, 3, 1, 4);
        pulse_flush();
        for (int i = 0; i < 16; i++) begin
            dispatch(op_b_reg, 0, ARCH_REG_BITS'(2 * i), ARCH_REG_BITS'(2 * i + 1));
        end
        dispatch(op_b_imm, 10, 0, 0);

        test_name = "random_mix";
        for (int n = 0; n < N_RANDOM; n++) begin
            pick = rand_below(20);
            if (pick < 10) begin
                op  = op_list[rand_below(9)];
                r_d = ARCH_REG_BITS'(rand_below(ARCH_REGS));
                r_a = ARCH_REG_BITS'(rand_below(ARCH_REGS));
                r_b = ARCH_REG_BITS'(rand_below(ARCH_REGS));
                if (writes_rd(op, r_d) && m_tail == m_head) begin
                    commit_oldest();
                end
                dispatch(op, r_d, r_a, r_b);
            end else if (pick < 14) begin
                if (inflight_rd.size() > 0) commit_oldest();
            end else if (pick < 19) begin
                if (inflight_rd.size() > 0) begin
                    idx = rand_below(inflight_rd.size());
                    write_cdb(rand_below(2) == 1, inflight_rd[idx], inflight_pd[idx]);
                end
            end else begin
                pulse_flush();
            end
        end

        if (expected_q.size() != 0) begin
            $display("%0d renamed results were never acked", expected_q.size());
            other_errors++;
        end
        $display("acks checked %0d, value errors %0d, other errors %0d",
                 acks_checked, value_errors, other_errors);
        if (value_errors == 0 && other_errors == 0) begin
            $display("Testbench passed");
        end else begin
            $display("Testbench failed");
        end
        $finish;
    end

endmodule : tb_rename
